//--- filelist.f
hw/rv_pkg.sv
hw/rv_decoded_if.sv
hw/rv_reg_read_if.sv
hw/rv_fetch_decode.sv
hw/rv_reg_file.sv
hw/rv_execute.sv
hw/rv_core_top.sv
verification/rv_core_asserts.sv
verification/tb_rv_core.sv

//--- hw/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t i_insn,
  output rv_pkg::word_t o_pc,
  output rv_pkg::word_t o_dmem_addr,
  output rv_pkg::word_t o_dmem_wdata,
  output logic          o_dmem_we,
  input  rv_pkg::word_t i_dmem_rdata,
  output logic          o_halt
);

  rv_pkg::word_t     next_pc;
  logic              rf_we;
  rv_pkg::reg_addr_t rf_rd;
  rv_pkg::word_t     rf_data;

  rv_decoded_if  dec_bus ();
  rv_reg_read_if rd_bus ();

  // PC and decode
  rv_fetch_decode #(
    .RESET_PC (RESET_PC)
  ) u_fetch_decode (
    .clk       (clk),
    .rst       (rst),
    .i_insn    (i_insn),
    .i_next_pc (next_pc),
    .o_pc      (o_pc),
    .dec       (dec_bus.producer)
  );

  rv_reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .i_we      (rf_we),
    .i_rd      (rf_rd),
    .i_rd_data (rf_data),
    .rd_port   (rd_bus.responder)
  );

  // ALU, branches and memory requests
  rv_execute u_execute (
    .dec          (dec_bus.consumer),
    .rd_port      (rd_bus.requester),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_rf_we      (rf_we),
    .o_rf_rd      (rf_rd),
    .o_rf_data    (rf_data),
    .o_next_pc    (next_pc),
    .o_halt       (o_halt)
  );

endmodule

//--- hw/rv_decoded_if.sv
`timescale 1ns/1ps

interface rv_decoded_if;
  rv_pkg::word_t     pc;
  rv_pkg::opcode_t   opcode;
  rv_pkg::funct3_t   funct3;
  // Bit 30 picks SUB, SRA and SRAI
  logic              alt;
  rv_pkg::reg_addr_t rd;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  // Already sign-extended for the opcode's format
  rv_pkg::word_t     imm;

  modport producer (
    output pc, opcode, funct3, alt, rd, rs1, rs2, imm
  );

  modport consumer (
    input pc, opcode, funct3, alt, rd, rs1, rs2, imm
  );

endinterface

//--- hw/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  rv_decoded_if.consumer     dec,
  rv_reg_read_if.requester   rd_port,
  input  rv_pkg::word_t      i_dmem_rdata,
  output rv_pkg::word_t      o_dmem_addr,
  output rv_pkg::word_t      o_dmem_wdata,
  output logic               o_dmem_we,
  output logic               o_rf_we,
  output rv_pkg::reg_addr_t  o_rf_rd,
  output rv_pkg::word_t      o_rf_data,
  output rv_pkg::word_t      o_next_pc,
  output logic               o_halt
);

  logic          is_lui;
  logic          is_jal;
  logic          is_jalr;
  logic          is_branch;
  logic          is_load;
  logic          is_store;
  logic          is_alu_imm;
  logic          is_alu_reg;
  logic          is_ecall;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t addr_sum;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_target;
  logic          take_branch;

  assign rd_port.rs1 = dec.rs1;
  assign rd_port.rs2 = dec.rs2;

  // Instruction classes
  assign is_lui     = dec.opcode == rv_pkg::OP_LUI;
  assign is_jal     = dec.opcode == rv_pkg::OP_JAL;
  assign is_jalr    = dec.opcode == rv_pkg::OP_JALR;
  assign is_branch  = dec.opcode == rv_pkg::OP_BRANCH;
  assign is_load    = (dec.opcode == rv_pkg::OP_LOAD) && (dec.funct3 == rv_pkg::F3_LW_SW);
  assign is_store   = (dec.opcode == rv_pkg::OP_STORE) && (dec.funct3 == rv_pkg::F3_LW_SW);
  assign is_alu_imm = dec.opcode == rv_pkg::OP_REG_IMM;
  assign is_alu_reg = dec.opcode == rv_pkg::OP_REG_REG;
  // ECALL has every field above the opcode at zero
  assign is_ecall   = (dec.opcode == rv_pkg::OP_ENVIRON) && (dec.funct3 == '0) &&
                      (dec.rd == '0) && (dec.rs1 == '0) && (dec.imm == '0);

  // ALU operands
  assign op_a = rd_port.rs1_data;
  assign op_b = is_alu_reg ? rd_port.rs2_data : dec.imm;

  always_comb begin
    case (dec.funct3)
      rv_pkg::F3_ADD: begin
        // Subtract only exists in the register form
        if (is_alu_reg && dec.alt) begin
          alu_result = op_a - op_b;
        end else begin
          alu_result = op_a + op_b;
        end
      end
      rv_pkg::F3_SLL:  alu_result = op_a << op_b[4:0];
      rv_pkg::F3_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::F3_SLTU: alu_result = {31'b0, op_a < op_b};
      rv_pkg::F3_XOR:  alu_result = op_a ^ op_b;
      rv_pkg::F3_SR: begin
        if (dec.alt) begin
          alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
        end else begin
          alu_result = op_a >> op_b[4:0];
        end
      end
      rv_pkg::F3_OR:   alu_result = op_a | op_b;
      default:         alu_result = op_a & op_b;
    endcase
  end

  // Branch condition
  always_comb begin
    case (dec.funct3)
      rv_pkg::F3_BEQ:  take_branch = op_a == rd_port.rs2_data;
      rv_pkg::F3_BNE:  take_branch = op_a != rd_port.rs2_data;
      rv_pkg::F3_BLT:  take_branch = $signed(op_a) < $signed(rd_port.rs2_data);
      rv_pkg::F3_BGE:  take_branch = $signed(op_a) >= $signed(rd_port.rs2_data);
      rv_pkg::F3_BLTU: take_branch = op_a < rd_port.rs2_data;
      rv_pkg::F3_BGEU: take_branch = op_a >= rd_port.rs2_data;
      default:         take_branch = 1'b0;
    endcase
  end

  // One adder serves load/store addresses and the JALR target
  assign addr_sum  = op_a + dec.imm;
  assign pc_plus4  = dec.pc + rv_pkg::INSN_BYTES;
  assign pc_target = dec.pc + dec.imm;

  always_comb begin
    if (is_ecall) begin
      o_next_pc = dec.pc;
    end else if (is_jalr) begin
      o_next_pc = {addr_sum[31:1], 1'b0};
    end else if (is_jal || (is_branch && take_branch)) begin
      o_next_pc = pc_target;
    end else begin
      o_next_pc = pc_plus4;
    end
  end

  // Data memory request
  assign o_dmem_addr  = addr_sum;
  assign o_dmem_wdata = rd_port.rs2_data;
  assign o_dmem_we    = is_store;

  // Write-back
  assign o_rf_we = is_lui || is_jal || is_jalr || is_load || is_alu_imm || is_alu_reg;
  assign o_rf_rd = dec.rd;

  always_comb begin
    if (is_lui) begin
      o_rf_data = dec.imm;
    end else if (is_jal || is_jalr) begin
      o_rf_data = pc_plus4;
    end else if (is_load) begin
      o_rf_data = i_dmem_rdata;
    end else begin
      o_rf_data = alu_result;
    end
  end

  assign o_halt = is_ecall;

endmodule

//--- hw/rv_fetch_decode.sv
`timescale 1ns/1ps

module rv_fetch_decode #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::word_t  i_insn,
  input  rv_pkg::word_t  i_next_pc,
  output rv_pkg::word_t  o_pc,
  rv_decoded_if.producer dec
);

  rv_pkg::word_t    pc_q;
  rv_pkg::opcode_t  opcode;
  rv_pkg::imm_fmt_t imm_fmt;
  rv_pkg::word_t    imm_i;
  rv_pkg::word_t    imm_s;
  rv_pkg::word_t    imm_b;
  rv_pkg::word_t    imm_j;
  rv_pkg::word_t    imm_u;
  rv_pkg::word_t    imm;

  // Program counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= i_next_pc;
    end
  end

  assign o_pc   = pc_q;
  assign opcode = i_insn[6:0];

  // Sign-extended immediates, one per encoding
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                  i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                  i_insn[30:21], 1'b0};
  // Upper immediate fills the low 12 bits with zeros
  assign imm_u = {i_insn[31:12], 12'b0};

  // Format follows the opcode, I-type for everything else
  always_comb begin
    case (opcode)
      rv_pkg::OP_STORE: begin
        imm_fmt = rv_pkg::IMM_S;
      end
      rv_pkg::OP_BRANCH: begin
        imm_fmt = rv_pkg::IMM_B;
      end
      rv_pkg::OP_JAL: begin
        imm_fmt = rv_pkg::IMM_J;
      end
      rv_pkg::OP_LUI: begin
        imm_fmt = rv_pkg::IMM_U;
      end
      default: begin
        imm_fmt = rv_pkg::IMM_I;
      end
    endcase
  end

  always_comb begin
    case (imm_fmt)
      rv_pkg::IMM_S: imm = imm_s;
      rv_pkg::IMM_B: imm = imm_b;
      rv_pkg::IMM_J: imm = imm_j;
      rv_pkg::IMM_U: imm = imm_u;
      default:       imm = imm_i;
    endcase
  end

  // Decoded fields to execute
  assign dec.pc     = pc_q;
  assign dec.opcode = opcode;
  assign dec.funct3 = i_insn[14:12];
  assign dec.alt    = i_insn[30];
  assign dec.rd     = i_insn[11:7];
  assign dec.rs1    = i_insn[19:15];
  assign dec.rs2    = i_insn[24:20];
  assign dec.imm    = imm;

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

  // Architectural widths
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;

  // Immediate layout selector
  typedef logic [2:0]            imm_fmt_t;

  // Major opcodes
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_JAL     = 7'b1101111;
  localparam opcode_t OP_JALR    = 7'b1100111;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_LOAD    = 7'b0000011;
  localparam opcode_t OP_STORE   = 7'b0100011;
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_REG_REG = 7'b0110011;
  localparam opcode_t OP_ENVIRON = 7'b1110011;

  // ALU funct3, shared by register-immediate and register-register forms
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Only word accesses are supported
  localparam funct3_t F3_LW_SW = 3'b010;

  localparam word_t INSN_BYTES = 32'd4;

  // Immediate formats
  localparam imm_fmt_t IMM_I = 3'd0;
  localparam imm_fmt_t IMM_S = 3'd1;
  localparam imm_fmt_t IMM_B = 3'd2;
  localparam imm_fmt_t IMM_J = 3'd3;
  localparam imm_fmt_t IMM_U = 3'd4;

endpackage

//--- hw/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_we,
  input  rv_pkg::reg_addr_t i_rd,
  input  rv_pkg::word_t     i_rd_data,
  rv_reg_read_if.responder  rd_port
);

  // x0 has no storage
  rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // Combinational reads, x0 reads as zero
  always_comb begin
    if (rd_port.rs1 == '0) begin
      rd_port.rs1_data = '0;
    end else begin
      rd_port.rs1_data = regs[rd_port.rs1];
    end
    if (rd_port.rs2 == '0) begin
      rd_port.rs2_data = '0;
    end else begin
      rd_port.rs2_data = regs[rd_port.rs2];
    end
  end

endmodule

//--- hw/rv_reg_read_if.sv
`timescale 1ns/1ps

interface rv_reg_read_if;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;

  // Execute asks, the register file answers in the same cycle
  modport requester (
    output rs1, rs2,
    input  rs1_data, rs2_data
  );

  modport responder (
    input  rs1, rs2,
    output rs1_data, rs2_data
  );

endinterface

//--- run.sh
#!/bin/bash
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_core -f filelist.f \
  --Mdir obj_dir -o sim_rv_core > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_rv_core > sim.log 2>&1

grep -q "Something failed" sim.log \
  && { echo "Simulation failed, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

//--- verification/rv_core_asserts.sv
`timescale 1ns/1ps

module rv_core_asserts (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t i_pc,
  input rv_pkg::word_t i_dmem_addr,
  input logic          i_dmem_we,
  input logic          i_halt
);

  // Fetch address stays on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (rst) i_pc[1:0] == 2'b00)
    else $error("PC is not word aligned");

  // Only word stores exist
  store_aligned: assert property (@(posedge clk) disable iff (rst)
    i_dmem_we |-> (i_dmem_addr[1:0] == 2'b00))
    else $error("Store address is not word aligned");

  // Halted core holds its PC
  halt_holds_pc: assert property (@(posedge clk) disable iff (rst)
    i_halt |=> (i_pc == $past(i_pc)))
    else $error("PC moved while halted");

endmodule

bind rv_core_top rv_core_asserts u_core_asserts (
  .clk         (clk),
  .rst         (rst),
  .i_pc        (o_pc),
  .i_dmem_addr (o_dmem_addr),
  .i_dmem_we   (o_dmem_we),
  .i_halt      (o_halt)
);

//--- verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  logic          clk;
  logic          rst;
  rv_pkg::word_t insn;
  rv_pkg::word_t pc;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  logic          dmem_we;
  rv_pkg::word_t dmem_rdata;
  logic          halt;

  rv_pkg::word_t imem [0:255];
  rv_pkg::word_t dmem [0:255];
  // Architectural model state
  rv_pkg::word_t m_mem [0:255];
  rv_pkg::word_t m_regs [0:31];
  rv_pkg::word_t m_pc;
  logic          checking;
  logic          mem_clear;
  int            prog_len;
  string         test_name;

  rv_core_top #(
    .RESET_PC (32'h0)
  ) dut0 (
    .clk          (clk),
    .rst          (rst),
    .i_insn       (insn),
    .o_pc         (pc),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata),
    .o_halt       (halt)
  );

  always #50 clk = ~clk;

  // Memories answer combinationally
  assign insn       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  function automatic rv_pkg::word_t fill_word(int idx);
    return (rv_pkg::word_t'(idx) * 32'h9e3779b1) ^ 32'h00c0ffee;
  endfunction

  always @(posedge clk) begin
    if (mem_clear) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  task automatic check_value(input string what, input rv_pkg::word_t exp,
                             input rv_pkg::word_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", what, exp, act);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic rv_pkg::word_t alu_ref(rv_pkg::funct3_t f3, logic alt,
                                            rv_pkg::word_t a, rv_pkg::word_t b);
    rv_pkg::word_t sra;
    sra = $signed(a) >>> b[4:0];
    case (f3)
      rv_pkg::F3_ADD:  return alt ? a - b : a + b;
      rv_pkg::F3_SLL:  return a << b[4:0];
      rv_pkg::F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
      rv_pkg::F3_SLTU: return {31'b0, a < b};
      rv_pkg::F3_XOR:  return a ^ b;
      rv_pkg::F3_SR:   return alt ? sra : a >> b[4:0];
      rv_pkg::F3_OR:   return a | b;
      default:         return a & b;
    endcase
  endfunction

  // One architectural step of the model at m_pc
  function automatic void ref_step(input rv_pkg::word_t ins, output rv_pkg::word_t nxt,
                                   output logic we, output rv_pkg::word_t addr,
                                   output rv_pkg::word_t wdata, output logic hlt);
    rv_pkg::funct3_t f3;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_j;
    rv_pkg::word_t   res;
    logic            wr;
    logic            taken;
    f3    = ins[14:12];
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt   = m_pc + 32'd4;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    hlt   = 1'b0;
    wr    = 1'b0;
    res   = '0;
    taken = 1'b0;
    case (ins[6:0])
      rv_pkg::OP_LUI: begin
        wr  = 1'b1;
        res = {ins[31:12], 12'b0};
      end
      rv_pkg::OP_JAL: begin
        wr  = 1'b1;
        res = m_pc + 32'd4;
        nxt = m_pc + imm_j;
      end
      rv_pkg::OP_JALR: begin
        wr  = 1'b1;
        res = m_pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1;
      end
      rv_pkg::OP_BRANCH: begin
        case (f3)
          rv_pkg::F3_BEQ:  taken = a == b;
          rv_pkg::F3_BNE:  taken = a != b;
          rv_pkg::F3_BLT:  taken = $signed(a) < $signed(b);
          rv_pkg::F3_BGE:  taken = $signed(a) >= $signed(b);
          rv_pkg::F3_BLTU: taken = a < b;
          rv_pkg::F3_BGEU: taken = a >= b;
          default:         taken = 1'b0;
        endcase
        if (taken) begin
          nxt = m_pc + imm_b;
        end
      end
      rv_pkg::OP_LOAD: begin
        if (f3 == rv_pkg::F3_LW_SW) begin
          wr   = 1'b1;
          addr = a + imm_i;
          res  = m_mem[addr[9:2]];
          addr = '0;
        end
      end
      rv_pkg::OP_STORE: begin
        if (f3 == rv_pkg::F3_LW_SW) begin
          we    = 1'b1;
          addr  = a + imm_s;
          wdata = b;
          m_mem[addr[9:2]] = b;
        end
      end
      rv_pkg::OP_REG_IMM: begin
        wr  = 1'b1;
        res = alu_ref(f3, (f3 == rv_pkg::F3_SR) && ins[30], a, imm_i);
      end
      rv_pkg::OP_REG_REG: begin
        wr  = 1'b1;
        res = alu_ref(f3, ins[30], a, b);
      end
      rv_pkg::OP_ENVIRON: begin
        if (ins[31:7] == '0) begin
          hlt = 1'b1;
          nxt = m_pc;
        end
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    if (wr && (ins[11:7] != 5'd0)) begin
      m_regs[ins[11:7]] = res;
    end
  endfunction

  task automatic compare_step();
    rv_pkg::word_t nxt;
    rv_pkg::word_t ea;
    rv_pkg::word_t ed;
    logic          ew;
    logic          eh;
    ref_step(imem[m_pc[9:2]], nxt, ew, ea, ed, eh);
    check_value({test_name, " pc"}, m_pc, pc);
    check_value({test_name, " halt"}, {31'b0, eh}, {31'b0, halt});
    check_value({test_name, " dmem_we"}, {31'b0, ew}, {31'b0, dmem_we});
    if (ew) begin
      check_value({test_name, " dmem_addr"}, ea, dmem_addr);
      check_value({test_name, " dmem_wdata"}, ed, dmem_wdata);
    end
    m_pc = nxt;
  endtask

  // Compare just before each rising edge, where outputs are settled
  always begin
    @(negedge clk);
    #40;
    if (checking) begin
      compare_step();
    end
  end

  function automatic rv_pkg::word_t enc_i(rv_pkg::opcode_t op, rv_pkg::funct3_t f3,
                                          rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1,
                                          logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_r(rv_pkg::funct3_t f3, logic alt,
                                          rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1,
                                          rv_pkg::reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OP_REG_REG};
  endfunction

  function automatic rv_pkg::word_t enc_s(rv_pkg::reg_addr_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, rv_pkg::F3_LW_SW, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_b(rv_pkg::funct3_t f3, logic [12:0] off);
    // Always compares x1 with x2
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
  endfunction

  task automatic emit(input rv_pkg::word_t word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    prog_len = 0;
  endtask

  task automatic run_program(input string name);
    int            cycles;
    rv_pkg::word_t halt_pc;
    test_name = name;
    checking  = 1'b0;
    @(negedge clk);
    rst       = 1'b1;
    mem_clear = 1'b1;
    @(negedge clk);
    mem_clear = 1'b0;
    @(negedge clk);
    rst  = 1'b0;
    m_pc = '0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      m_mem[i] = fill_word(i);
    end
    check_value({name, " reset pc"}, 32'h0, pc);
    check_value({name, " reset dmem_we"}, 32'h0, {31'b0, dmem_we});
    checking = 1'b1;
    cycles   = 0;
    while (!halt && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("Core never halted during %s", name);
      $display("Something failed");
      $fatal(1, "halt timeout");
    end
    // Model PC sits on the ECALL here
    halt_pc = m_pc;
    repeat (5) @(negedge clk);
    check_value({name, " halted pc"}, halt_pc, pc);
    checking = 1'b0;
  endtask

  task automatic gen_alu_program();
    rv_pkg::funct3_t   f3;
    rv_pkg::reg_addr_t rd;
    logic [11:0]       imm;
    logic              alt;
    clear_program();
    for (int k = 1; k < 8; k++) begin
      emit({20'($urandom), 5'(k), rv_pkg::OP_LUI});
      emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'(k), 5'(k), 12'($urandom)));
    end
    for (int k = 0; k < 40; k++) begin
      f3  = rv_pkg::funct3_t'($urandom);
      rd  = rv_pkg::reg_addr_t'(1 + $urandom % 7);
      alt = 1'($urandom);
      if ($urandom % 2 == 0) begin
        imm = 12'($urandom);
        if (f3 == rv_pkg::F3_SLL) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == rv_pkg::F3_SR) begin
          imm = {1'b0, alt, 5'b0, imm[4:0]};
        end
        emit(enc_i(rv_pkg::OP_REG_IMM, f3, rd, 5'(1 + $urandom % 7), imm));
      end else begin
        if (f3 != rv_pkg::F3_ADD && f3 != rv_pkg::F3_SR) begin
          alt = 1'b0;
        end
        emit(enc_r(f3, alt, rd, 5'(1 + $urandom % 7), 5'(1 + $urandom % 7)));
      end
      emit(enc_s(rd, 12'(k * 4)));
    end
    emit({25'b0, rv_pkg::OP_ENVIRON});
  endtask

  task automatic gen_branch_program(output rv_pkg::word_t jal_link,
                                    output rv_pkg::word_t jalr_link);
    rv_pkg::funct3_t brs [6];
    logic [11:0]     av;
    logic [11:0]     bv;
    int              p;
    brs = '{rv_pkg::F3_BEQ, rv_pkg::F3_BNE, rv_pkg::F3_BLT,
            rv_pkg::F3_BGE, rv_pkg::F3_BLTU, rv_pkg::F3_BGEU};
    clear_program();
    // Operand pairs split signed from unsigned order, plus equality
    for (int b = 0; b < 6; b++) begin
      for (int c = 0; c < 3; c++) begin
        av = (c == 0) ? 12'hfff : (c == 1) ? 12'h001 : 12'h005;
        bv = (c == 0) ? 12'h001 : (c == 1) ? 12'hfff : 12'h005;
        emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd1, 5'd0, av));
        emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd2, 5'd0, bv));
        emit(enc_b(brs[b], 13'd8));
        emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd5, 5'd5, 12'd1));
      end
    end
    emit(enc_s(5'd5, 12'd0));
    jal_link = rv_pkg::word_t'(prog_len * 4 + 4);
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd6, rv_pkg::OP_JAL});
    emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd7, 5'd7, 12'd1));
    emit(enc_s(5'd6, 12'd4));
    // JALR target with bit 0 set, which the jump clears
    p = prog_len;
    jalr_link = rv_pkg::word_t'((p + 1) * 4 + 4);
    emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd8, 5'd0, 12'((p + 3) * 4)));
    emit(enc_i(rv_pkg::OP_JALR, 3'b000, 5'd9, 5'd8, 12'd1));
    emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd7, 5'd7, 12'd1));
    emit(enc_s(5'd9, 12'd8));
    emit(enc_s(5'd7, 12'd12));
    emit({25'b0, rv_pkg::OP_ENVIRON});
  endtask

  initial begin
    rv_pkg::word_t jal_link;
    rv_pkg::word_t jalr_link;
    clk        = 1'b0;
    rst        = 1'b1;
    checking   = 1'b0;
    mem_clear  = 1'b0;
    void'($urandom(32'ha8d3));
    clear_program();

    gen_alu_program();
    run_program("alu");

    // x0 ignores ALU and LUI results
    clear_program();
    emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_ADD, 5'd0, 5'd0, 12'h123));
    emit({20'habcde, 5'd0, rv_pkg::OP_LUI});
    emit(enc_r(rv_pkg::F3_OR, 1'b0, 5'd0, 5'd0, 5'd0));
    emit(enc_s(5'd0, 12'd0));
    emit({25'b0, rv_pkg::OP_ENVIRON});
    run_program("x0");
    check_value("x0 stored word", 32'h0, dmem[0]);

    gen_branch_program(jal_link, jalr_link);
    run_program("branch");
    check_value("jal link", jal_link, dmem[1]);
    check_value("jalr link", jalr_link, dmem[2]);

    // Store, load back, store again
    clear_program();
    emit({20'($urandom), 5'd1, rv_pkg::OP_LUI});
    emit(enc_i(rv_pkg::OP_REG_IMM, rv_pkg::F3_XOR, 5'd1, 5'd1, 12'($urandom)));
    emit(enc_s(5'd1, 12'd16));
    emit(enc_i(rv_pkg::OP_LOAD, rv_pkg::F3_LW_SW, 5'd2, 5'd0, 12'd16));
    emit(enc_s(5'd2, 12'd20));
    emit(enc_i(rv_pkg::OP_LOAD, rv_pkg::F3_LW_SW, 5'd3, 5'd0, 12'd40));
    emit(enc_s(5'd3, 12'd24));
    emit({25'b0, rv_pkg::OP_ENVIRON});
    run_program("load");

    $display("Everything OK");
    $finish;
  end

endmodule
